// File: include/muldiv_defines.svh
//--------------------------------------------------------------------------
// Width and depth macros for the integer multiply/divide unit
//--------------------------------------------------------------------------

`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// Operand and result width
`define MULDIV_XLEN 32

// Function code field
`define MULDIV_FUNC_NBITS 2

// Order queue, one slot per engine
`define MULDIV_ORDER_DEPTH 2

`endif

// File: hw/muldiv_pkg.sv
//--------------------------------------------------------------------------
// Function codes, engine ids and iterative FSM states
//--------------------------------------------------------------------------

`include "muldiv_defines.svh"

package muldiv_pkg;

  // Request function codes
  typedef enum logic [`MULDIV_FUNC_NBITS-1:0] {
    FUNC_MUL  = 2'd0,
    FUNC_DIVU = 2'd1,
    FUNC_REMU = 2'd2
  } muldiv_func_e;

  // Engine that owns a request, kept in the order queue
  typedef enum logic {
    ENGINE_MUL = 1'b0,
    ENGINE_DIV = 1'b1
  } muldiv_engine_e;

  // Shared by both engine FSMs
  typedef enum logic [1:0] {
    STATE_IDLE = 2'd0,
    STATE_CALC = 2'd1,
    STATE_DONE = 2'd2
  } iter_state_e;

endpackage

// File: hw/int_mul_var_lat.sv
//--------------------------------------------------------------------------
// Variable-latency shift-and-add multiplier, skips zero runs in B
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "muldiv_defines.svh"

module int_mul_var_lat
  import muldiv_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,

  // Request
  input  logic                    in_val,
  output logic                    in_rdy,
  input  logic [`MULDIV_XLEN-1:0] in_a,
  input  logic [`MULDIV_XLEN-1:0] in_b,

  // Response
  output logic                    out_val,
  input  logic                    out_rdy,
  output logic [`MULDIV_XLEN-1:0] out_msg
);

  iter_state_e             state;
  iter_state_e             state_next;

  logic [`MULDIV_XLEN-1:0] a_reg;
  logic [`MULDIV_XLEN-1:0] b_reg;
  logic [`MULDIV_XLEN-1:0] result_reg;

  logic [3:0]              zero_cnt;
  logic [`MULDIV_XLEN-1:0] a_shift;
  logic [`MULDIV_XLEN-1:0] b_shift;
  logic [`MULDIV_XLEN-1:0] a_next;
  logic [`MULDIV_XLEN-1:0] b_next;
  logic [`MULDIV_XLEN-1:0] result_next;
  logic                    in_go;
  logic                    out_go;
  logic                    calc_done;

  //------------------------------------------------------------------------
  // Datapath
  //------------------------------------------------------------------------

  // Trailing zeros of the low byte, 8 when the byte is clear
  always_comb begin
    zero_cnt = 4'd8;
    for (int i = 7; i >= 0; i--) begin
      if (b_reg[i]) begin
        zero_cnt = i[3:0];
      end
    end
  end

  // Skip the zero run, then consume one more bit
  assign a_shift = a_reg << zero_cnt;
  assign b_shift = b_reg >> zero_cnt;
  assign a_next  = a_shift << 1;
  assign b_next  = b_shift >> 1;

  // Accumulate only on a set bit
  assign result_next = b_shift[0] ? (result_reg + a_shift) : result_reg;

  // Nothing left in B after this step
  assign calc_done = (b_next == '0);

  always_ff @(posedge clk) begin
    if (in_go) begin
      a_reg      <= in_a;
      b_reg      <= in_b;
      result_reg <= '0;
    end else if (state == STATE_CALC) begin
      a_reg      <= a_next;
      b_reg      <= b_next;
      result_reg <= result_next;
    end
  end

  //------------------------------------------------------------------------
  // Control FSM
  //------------------------------------------------------------------------

  assign in_go  = in_val && in_rdy;
  assign out_go = out_val && out_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= STATE_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      STATE_IDLE: if (in_go)     state_next = STATE_CALC;
      STATE_CALC: if (calc_done) state_next = STATE_DONE;
      STATE_DONE: if (out_go)    state_next = STATE_IDLE;
      default:                   state_next = STATE_IDLE;
    endcase
  end

  // Handshake straight from the state
  assign in_rdy  = (state == STATE_IDLE);
  assign out_val = (state == STATE_DONE);
  assign out_msg = result_reg;

endmodule

// File: hw/int_div_iter.sv
//--------------------------------------------------------------------------
// Iterative restoring divider, unsigned quotient or remainder
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "muldiv_defines.svh"

module int_div_iter
  import muldiv_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,

  // Request
  input  logic                    in_val,
  output logic                    in_rdy,
  input  logic [`MULDIV_XLEN-1:0] in_a,
  input  logic [`MULDIV_XLEN-1:0] in_b,
  input  logic                    div_is_rem,

  // Response
  output logic                    out_val,
  input  logic                    out_rdy,
  output logic [`MULDIV_XLEN-1:0] out_msg
);

  localparam int STEP_NBITS = $clog2(`MULDIV_XLEN);

  iter_state_e             state;
  iter_state_e             state_next;

  logic [`MULDIV_XLEN-1:0] rem_reg;
  logic [`MULDIV_XLEN-1:0] quo_reg;
  logic [`MULDIV_XLEN-1:0] dvsr_reg;
  logic                    is_rem_reg;
  logic [STEP_NBITS-1:0]   step;

  logic [`MULDIV_XLEN:0]   rem_shift;
  logic [`MULDIV_XLEN+1:0] diff;
  logic                    diff_neg;
  logic                    in_go;
  logic                    out_go;
  logic                    last_step;

  //------------------------------------------------------------------------
  // Datapath
  //------------------------------------------------------------------------

  // Next dividend bit moves from the quotient into the remainder
  assign rem_shift = {rem_reg, quo_reg[`MULDIV_XLEN-1]};

  // Trial subtract, one extra bit for the sign
  assign diff     = {1'b0, rem_shift} - {2'b00, dvsr_reg};
  assign diff_neg = diff[`MULDIV_XLEN+1];

  always_ff @(posedge clk) begin
    if (in_go) begin
      rem_reg    <= '0;
      quo_reg    <= in_a;
      dvsr_reg   <= in_b;
      is_rem_reg <= div_is_rem;
    end else if (state == STATE_CALC) begin
      // Restore on a negative difference
      rem_reg <= diff_neg ? rem_shift[`MULDIV_XLEN-1:0] : diff[`MULDIV_XLEN-1:0];
      quo_reg <= {quo_reg[`MULDIV_XLEN-2:0], ~diff_neg};
    end
  end

  //------------------------------------------------------------------------
  // Control FSM and step counter
  //------------------------------------------------------------------------

  assign in_go     = in_val && in_rdy;
  assign out_go    = out_val && out_rdy;
  assign last_step = (step == STEP_NBITS'(`MULDIV_XLEN - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= STATE_IDLE;
      step  <= '0;
    end else begin
      state <= state_next;
      if (in_go) begin
        step <= '0;
      end else if (state == STATE_CALC) begin
        step <= step + 1'b1;
      end
    end
  end

  // Exactly one CALC cycle per quotient bit
  always_comb begin
    state_next = state;
    case (state)
      STATE_IDLE: if (in_go)     state_next = STATE_CALC;
      STATE_CALC: if (last_step) state_next = STATE_DONE;
      STATE_DONE: if (out_go)    state_next = STATE_IDLE;
      default:                   state_next = STATE_IDLE;
    endcase
  end

  assign in_rdy  = (state == STATE_IDLE);
  assign out_val = (state == STATE_DONE);
  assign out_msg = is_rem_reg ? rem_reg : quo_reg;

endmodule

// File: hw/muldiv_order_ctrl.sv
//--------------------------------------------------------------------------
// Request steering and in-order response merge for the two engines
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "muldiv_defines.svh"

module muldiv_order_ctrl
  import muldiv_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,

  // Request side
  input  logic                    in_val,
  output logic                    in_rdy,
  input  muldiv_func_e            in_func,

  // Engine requests
  output logic                    mul_in_val,
  input  logic                    mul_in_rdy,
  output logic                    div_in_val,
  input  logic                    div_in_rdy,
  output logic                    div_is_rem,

  // Engine responses
  input  logic                    mul_out_val,
  output logic                    mul_out_rdy,
  input  logic [`MULDIV_XLEN-1:0] mul_out_msg,
  input  logic                    div_out_val,
  output logic                    div_out_rdy,
  input  logic [`MULDIV_XLEN-1:0] div_out_msg,

  // Response side
  output logic                    out_val,
  input  logic                    out_rdy,
  output logic [`MULDIV_XLEN-1:0] out_msg
);

  localparam int DEPTH     = `MULDIV_ORDER_DEPTH;
  localparam int PTR_NBITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_NBITS = $clog2(DEPTH + 1);

  muldiv_engine_e       order_q [DEPTH];
  logic [PTR_NBITS-1:0] wr_ptr;
  logic [PTR_NBITS-1:0] rd_ptr;
  logic [CNT_NBITS-1:0] count;

  muldiv_engine_e       req_engine;
  muldiv_engine_e       head_engine;
  logic                 full;
  logic                 empty;
  logic                 sel_rdy;
  logic                 push;
  logic                 pop;

  //------------------------------------------------------------------------
  // Request steering
  //------------------------------------------------------------------------

  assign req_engine = (in_func == FUNC_MUL) ? ENGINE_MUL : ENGINE_DIV;
  assign full       = (count == CNT_NBITS'(DEPTH));
  assign empty      = (count == '0);
  assign sel_rdy    = (req_engine == ENGINE_MUL) ? mul_in_rdy : div_in_rdy;

  // Accept only with a free queue slot
  assign in_rdy     = sel_rdy && !full;
  assign mul_in_val = in_val && !full && (req_engine == ENGINE_MUL);
  assign div_in_val = in_val && !full && (req_engine == ENGINE_DIV);
  assign div_is_rem = (in_func == FUNC_REMU);
  assign push       = in_val && in_rdy;

  //------------------------------------------------------------------------
  // Response merge, head engine only
  //------------------------------------------------------------------------

  assign head_engine = order_q[rd_ptr];
  assign mul_out_rdy = out_rdy && !empty && (head_engine == ENGINE_MUL);
  assign div_out_rdy = out_rdy && !empty && (head_engine == ENGINE_DIV);
  assign out_val     = !empty && ((head_engine == ENGINE_MUL) ? mul_out_val : div_out_val);
  assign out_msg     = (head_engine == ENGINE_MUL) ? mul_out_msg : div_out_msg;
  assign pop         = out_val && out_rdy;

  // Order queue
  always_ff @(posedge clk) begin
    if (push) begin
      order_q[wr_ptr] <= req_engine;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_NBITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_NBITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_NBITS'(push) - CNT_NBITS'(pop);
    end
  end

endmodule

// File: hw/muldiv_unit.sv
//--------------------------------------------------------------------------
// Multiply/divide unit top, two engines behind the order controller
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "muldiv_defines.svh"

module muldiv_unit
  import muldiv_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,

  // Requests
  input  logic                    in_val,
  output logic                    in_rdy,
  input  muldiv_func_e            in_func,
  input  logic [`MULDIV_XLEN-1:0] in_a,
  input  logic [`MULDIV_XLEN-1:0] in_b,

  // Responses, request order
  output logic                    out_val,
  input  logic                    out_rdy,
  output logic [`MULDIV_XLEN-1:0] out_msg
);

  logic                    mul_in_val;
  logic                    mul_in_rdy;
  logic                    mul_out_val;
  logic                    mul_out_rdy;
  logic [`MULDIV_XLEN-1:0] mul_out_msg;

  logic                    div_in_val;
  logic                    div_in_rdy;
  logic                    div_is_rem;
  logic                    div_out_val;
  logic                    div_out_rdy;
  logic [`MULDIV_XLEN-1:0] div_out_msg;

  // Steering and reorder
  muldiv_order_ctrl i_order_ctrl (
    .clk         (clk),
    .reset       (reset),
    .in_val      (in_val),
    .in_rdy      (in_rdy),
    .in_func     (in_func),
    .mul_in_val  (mul_in_val),
    .mul_in_rdy  (mul_in_rdy),
    .div_in_val  (div_in_val),
    .div_in_rdy  (div_in_rdy),
    .div_is_rem  (div_is_rem),
    .mul_out_val (mul_out_val),
    .mul_out_rdy (mul_out_rdy),
    .mul_out_msg (mul_out_msg),
    .div_out_val (div_out_val),
    .div_out_rdy (div_out_rdy),
    .div_out_msg (div_out_msg),
    .out_val     (out_val),
    .out_rdy     (out_rdy),
    .out_msg     (out_msg)
  );

  // Operands fan out to both engines
  int_mul_var_lat i_mul (
    .clk     (clk),
    .reset   (reset),
    .in_val  (mul_in_val),
    .in_rdy  (mul_in_rdy),
    .in_a    (in_a),
    .in_b    (in_b),
    .out_val (mul_out_val),
    .out_rdy (mul_out_rdy),
    .out_msg (mul_out_msg)
  );

  int_div_iter i_div (
    .clk        (clk),
    .reset      (reset),
    .in_val     (div_in_val),
    .in_rdy     (div_in_rdy),
    .in_a       (in_a),
    .in_b       (in_b),
    .div_is_rem (div_is_rem),
    .out_val    (div_out_val),
    .out_rdy    (div_out_rdy),
    .out_msg    (div_out_msg)
  );

endmodule

// File: verification/tb_muldiv_unit.sv
//--------------------------------------------------------------------------
// Testbench for the multiply/divide unit with random requests, a reference
// model, an in-order scoreboard, back-pressure checks and a watchdog
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "muldiv_defines.svh"

module tb_muldiv_unit
  import muldiv_pkg::*;
;

  localparam int      CLK_PERIOD     = 20;
  localparam int      RESET_CYCLES   = 10;
  localparam int      NUM_REQS       = 400;
  localparam longint  TIMEOUT_CYCLES = NUM_REQS * 40 * 4;

  logic                    clk;
  logic                    reset;
  logic                    in_val;
  logic                    in_rdy;
  muldiv_func_e            in_func;
  logic [`MULDIV_XLEN-1:0] in_a;
  logic [`MULDIV_XLEN-1:0] in_b;
  logic                    out_val;
  logic                    out_rdy;
  logic [`MULDIV_XLEN-1:0] out_msg;

  integer                  seed = 14532;
  logic [`MULDIV_XLEN-1:0] exp_q [$];
  int                      pushed;
  int                      received;
  int                      sent;
  int                      full_seen;
  int                      stall_left;
  logic                    req_fire;
  logic                    resp_fire;
  logic                    hold_active;
  logic [`MULDIV_XLEN-1:0] hold_msg;

  muldiv_unit i_dut (
    .clk     (clk),
    .reset   (reset),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_func (in_func),
    .in_a    (in_a),
    .in_b    (in_b),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_msg (out_msg)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //------------------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------------------

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Biased toward zero, all ones, sparse and small values
  function automatic logic [`MULDIV_XLEN-1:0] pick_operand();
    logic [`MULDIV_XLEN-1:0] v;
    case (rand_below(8))
      0:       v = '0;
      1:       v = '1;
      2, 3:    v = (32'd1 << rand_below(32)) | (32'd1 << rand_below(32));
      4:       v = rand_below(256);
      default: v = $random(seed);
    endcase
    return v;
  endfunction

  // Reference results from plain wide and unsigned arithmetic
  function automatic logic [`MULDIV_XLEN-1:0] model_result(
    muldiv_func_e f, logic [`MULDIV_XLEN-1:0] a, logic [`MULDIV_XLEN-1:0] b);
    logic [2*`MULDIV_XLEN-1:0] prod;
    prod = {{`MULDIV_XLEN{1'b0}}, a} * {{`MULDIV_XLEN{1'b0}}, b};
    case (f)
      FUNC_MUL:  return prod[`MULDIV_XLEN-1:0];
      FUNC_DIVU: return (b == '0) ? '1 : a / b;
      default:   return (b == '0) ? a : a % b;
    endcase
  endfunction

  task automatic drive_request();
    logic [1:0] code;
    code    = 2'(rand_below(3));
    in_func = muldiv_func_e'(code);
    in_a    = pick_operand();
    in_b    = pick_operand();
    in_val  = 1'b1;
  endtask

  task automatic value_mismatch(string name, logic [31:0] exp, logic [31:0] act);
    $display("Fail at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
    $display("SIMULATION FAILED");
    $fatal(1, "value mismatch on %s", name);
  endtask

  task automatic stop_with_error(string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("SIMULATION FAILED");
    $fatal(1, "%s", what);
  endtask

  //------------------------------------------------------------------------
  // Monitor sampled at the falling edge ahead of each transfer
  //------------------------------------------------------------------------

  always @(negedge clk) begin
    if (!reset) begin
      // Held response must not change or drop
      if (hold_active) begin
        assert (out_val) else stop_with_error("out_val dropped while out_rdy was low");
        assert (out_msg == hold_msg) else value_mismatch("out_msg", hold_msg, out_msg);
      end
      // Both engines occupied
      if (exp_q.size() == `MULDIV_ORDER_DEPTH) begin
        full_seen++;
        assert (!in_rdy) else stop_with_error("in_rdy high while both engines hold an item");
      end
      if (in_val && pushed == 0) begin
        assert (in_rdy) else stop_with_error("first request after reset was not accepted");
      end
      req_fire  = in_val && in_rdy;
      resp_fire = out_val && out_rdy;
      if (resp_fire) begin
        assert (exp_q.size() != 0)
          else stop_with_error("response arrived with no request outstanding");
        assert (out_msg == exp_q[0]) else value_mismatch("out_msg", exp_q[0], out_msg);
        void'(exp_q.pop_front());
        received++;
      end
      if (req_fire) begin
        exp_q.push_back(model_result(in_func, in_a, in_b));
        pushed++;
      end
      hold_active = out_val && !out_rdy;
      hold_msg    = out_msg;
    end
  end

  //------------------------------------------------------------------------
  // Stimulus
  //------------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    in_val = 1'b0;
    in_func = FUNC_MUL;
    in_a = '0;
    in_b = '0;
    out_rdy = 1'b0;
    pushed = 0;
    received = 0;
    sent = 0;
    full_seen = 0;
    stall_left = 0;
    req_fire = 1'b0;
    resp_fire = 1'b0;
    hold_active = 1'b0;
    hold_msg = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);
    assert (!out_val) else stop_with_error("out_val high right after reset");
    assert (in_rdy) else stop_with_error("in_rdy low right after reset");

    while (received < NUM_REQS) begin
      @(posedge clk);
      #1;
      if (in_val && req_fire) begin
        in_val = 1'b0;
        sent++;
      end
      // Random gaps between requests
      if (!in_val && sent < NUM_REQS && rand_below(4) != 0) begin
        drive_request();
      end
      // Occasional stall bursts on top of a mostly ready sink
      if (stall_left > 0) begin
        stall_left--;
        out_rdy = 1'b0;
      end else if (rand_below(32) == 0) begin
        stall_left = 4 + rand_below(32);
        out_rdy = 1'b0;
      end else begin
        out_rdy = (rand_below(8) != 0);
      end
    end

    @(negedge clk);
    if (out_val) begin
      stop_with_error("out_val still high after the last expected response");
    end else if (full_seen == 0) begin
      stop_with_error("both engines were never busy at the same time");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

  // Watchdog
  initial begin
    #((RESET_CYCLES + TIMEOUT_CYCLES) * CLK_PERIOD);
    $display("Error: responses stopped arriving, %0d of %0d received", received, NUM_REQS);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

// File: sim.f
+incdir+include
hw/muldiv_pkg.sv
hw/int_mul_var_lat.sv
hw/int_div_iter.sv
hw/muldiv_order_ctrl.sv
hw/muldiv_unit.sv
verification/tb_muldiv_unit.sv

// File: Makefile
# Verilator build and run for the multiply/divide unit

VERILATOR ?= verilator
TOP       ?= tb_muldiv_unit
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Run passed"; \
	else \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
